// File: Bender.yml
package:
  name: bram_replicate

export_include_dirs:
  - common

sources:
  - files:
      - common/bram_replicate_pkg.sv
      - bram_replicate/write_merge.sv
      - bram_replicate/bram_replica.sv
      - bram_replicate/read_return.sv
      - hdl/bram_replicate_top.sv
  - target: simulation
    files:
      - verif/bram_replicate_checker.sv
      - verif/tb_bram_replicate.sv

// File: bram_replicate/bram_replica.sv
`default_nettype none

module bram_replica #(
    parameter int DATA_WIDTH = 16,
    parameter int ADDR_WIDTH = 5
) (
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire logic                  we,
    input  wire logic [ADDR_WIDTH-1:0] waddr,
    input  wire logic [DATA_WIDTH-1:0] wdata,
    input  wire logic                  re,
    input  wire logic [ADDR_WIDTH-1:0] raddr,
    output logic                       rvalid,
    output logic      [DATA_WIDTH-1:0] rdata
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // Read sees the old word when both ports hit one address
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        if (re) begin
            rdata <= mem[raddr];
        end
    end

    // One-edge read latency
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rvalid <= 1'b0;
        end else begin
            rvalid <= re;
        end
    end

endmodule

`default_nettype wire

// File: bram_replicate/read_return.sv
`default_nettype none

`include "bram_replicate_config.svh"

module read_return (
    input  wire logic                       clk,
    input  wire logic                       arst_n,
    input  wire logic                       rd_en      [`BR_NUM_RD],
    input  wire logic                       rd_bram    [`BR_NUM_RD],
    input  wire logic                       mem_rvalid [`BR_NUM_RD],
    input  wire bram_replicate_pkg::word_t  mem_rdata  [`BR_NUM_RD],
    output logic                            rd_valid   [`BR_NUM_RD],
    output bram_replicate_pkg::word_t       rd_data    [`BR_NUM_RD]
);

    for (genvar k = 0; k < `BR_NUM_RD; k++) begin : gen_chan

        logic re_q;
        logic region_q;

        // ####################
        // Request delay
        // ####################

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                re_q     <= 1'b0;
                region_q <= 1'b0;
                rd_valid[k] <= 1'b0;
            end else begin
                re_q     <= rd_en[k];
                region_q <= rd_bram[k];
                rd_valid[k] <= mem_rvalid[k] & re_q & region_q;  // Only this region returns
            end
        end

        always_ff @(posedge clk) begin
            if (mem_rvalid[k]) begin
                rd_data[k] <= mem_rdata[k];
            end
        end

        // Replica valid lines up with the delayed qualifying request
        a_valid_has_req : assert property (
            @(posedge clk) disable iff (!arst_n)
            mem_rvalid[k] == (re_q && region_q)
        ) else $error("read_return: replica valid and request disagree on channel %0d", k);

    end

endmodule

`default_nettype wire

// File: bram_replicate/write_merge.sv
`default_nettype none

`include "bram_replicate_config.svh"

module write_merge (
    input  wire logic                       clk,
    input  wire logic                       arst_n,
    input  wire logic                       wr_en     [`BR_NUM_WR],
    input  wire logic                       wr_bram   [`BR_NUM_WR],
    input  wire bram_replicate_pkg::addr_t  wr_addr   [`BR_NUM_WR],
    input  wire bram_replicate_pkg::word_t  wr_data   [`BR_NUM_WR],
    output logic                            mem_we,
    output bram_replicate_pkg::addr_t       mem_waddr,
    output bram_replicate_pkg::word_t       mem_wdata
);

    logic [`BR_NUM_WR-1:0]     sel;       // Channel aims at this region
    bram_replicate_pkg::addr_t nxt_addr;
    bram_replicate_pkg::word_t nxt_data;

    for (genvar i = 0; i < `BR_NUM_WR; i++) begin : gen_sel
        assign sel[i] = wr_en[i] & wr_bram[i];
    end

    // Lowest selected channel wins, so scan from the top down
    always_comb begin
        nxt_addr = wr_addr[0];
        nxt_data = wr_data[0];
        for (int i = `BR_NUM_WR - 1; i >= 0; i--) begin
            if (sel[i]) begin
                nxt_addr = wr_addr[i];
                nxt_data = wr_data[i];
            end
        end
    end

    // ####################
    // Broadcast register
    // ####################

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_we <= 1'b0;
        end else begin
            mem_we <= |sel;
        end
    end

    always_ff @(posedge clk) begin
        if (|sel) begin
            mem_waddr <= nxt_addr;
            mem_wdata <= nxt_data;
        end
    end

    // Writers upstream must never target this region together
    a_single_writer : assert property (
        @(posedge clk) disable iff (!arst_n)
        $countones(sel) <= 1
    ) else $error("write_merge: more than one write channel selected in one cycle");

endmodule

`default_nettype wire

// File: common/bram_replicate_config.svh
`ifndef BRAM_REPLICATE_CONFIG_SVH
`define BRAM_REPLICATE_CONFIG_SVH

// ####################
// Memory geometry
// ####################

`define BR_DATA_WIDTH 16   // Bits per stored word
`define BR_ADDR_WIDTH 5    // 32 words per replica

// ####################
// Channel counts
// ####################

`define BR_NUM_WR 2
// One replica per read channel
`define BR_NUM_RD 3

`endif

// File: common/bram_replicate_pkg.sv
`default_nettype none

`include "bram_replicate_config.svh"

package bram_replicate_pkg;

    // ####################
    // Data path types
    // ####################

    // Stored word, used on both write and read data
    typedef logic [`BR_DATA_WIDTH-1:0] word_t;

    // Word address within one replica
    typedef logic [`BR_ADDR_WIDTH-1:0] addr_t;

endpackage

`default_nettype wire

// File: hdl/bram_replicate_top.sv
`default_nettype none

`include "bram_replicate_config.svh"

module bram_replicate_top (
    input  wire logic                       clk,
    input  wire logic                       arst_n,

    input  wire logic                       wr_en    [`BR_NUM_WR],
    input  wire logic                       wr_bram  [`BR_NUM_WR],
    input  wire bram_replicate_pkg::addr_t  wr_addr  [`BR_NUM_WR],
    input  wire bram_replicate_pkg::word_t  wr_data  [`BR_NUM_WR],

    input  wire logic                       rd_en    [`BR_NUM_RD],
    input  wire logic                       rd_bram  [`BR_NUM_RD],
    input  wire bram_replicate_pkg::addr_t  rd_addr  [`BR_NUM_RD],
    output logic                            rd_valid [`BR_NUM_RD],
    output bram_replicate_pkg::word_t       rd_data  [`BR_NUM_RD]
);

    logic                      mem_we;
    bram_replicate_pkg::addr_t mem_waddr;
    bram_replicate_pkg::word_t mem_wdata;
    logic                      mem_rvalid [`BR_NUM_RD];
    bram_replicate_pkg::word_t mem_rdata  [`BR_NUM_RD];

    write_merge write_merge_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr_en     (wr_en),
        .wr_bram   (wr_bram),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .mem_we    (mem_we),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata)
    );

    // ####################
    // Replicas
    // ####################

    for (genvar k = 0; k < `BR_NUM_RD; k++) begin : gen_replica
        bram_replica #(
            .DATA_WIDTH (`BR_DATA_WIDTH),
            .ADDR_WIDTH (`BR_ADDR_WIDTH)
        ) bram_replica_i (
            .clk    (clk),
            .arst_n (arst_n),
            .we     (mem_we),      // Same write into every copy
            .waddr  (mem_waddr),
            .wdata  (mem_wdata),
            .re     (rd_en[k] & rd_bram[k]),
            .raddr  (rd_addr[k]),
            .rvalid (mem_rvalid[k]),
            .rdata  (mem_rdata[k])
        );
    end

    read_return read_return_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .rd_en      (rd_en),
        .rd_bram    (rd_bram),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data)
    );

endmodule

`default_nettype wire

// File: sim.f
+incdir+common
common/bram_replicate_pkg.sv
bram_replicate/write_merge.sv
bram_replicate/bram_replica.sv
bram_replicate/read_return.sv
hdl/bram_replicate_top.sv
verif/bram_replicate_checker.sv
verif/tb_bram_replicate.sv

// File: verif/bram_replicate_checker.sv
`default_nettype none

`include "bram_replicate_config.svh"

module bram_replicate_checker (
    input  wire logic                       clk,
    input  wire logic                       arst_n,
    input  wire logic                       wr_en    [`BR_NUM_WR],
    input  wire logic                       wr_bram  [`BR_NUM_WR],
    input  wire bram_replicate_pkg::addr_t  wr_addr  [`BR_NUM_WR],
    input  wire bram_replicate_pkg::word_t  wr_data  [`BR_NUM_WR],
    input  wire logic                       rd_en    [`BR_NUM_RD],
    input  wire logic                       rd_bram  [`BR_NUM_RD],
    input  wire bram_replicate_pkg::addr_t  rd_addr  [`BR_NUM_RD],
    input  wire logic                       rd_valid [`BR_NUM_RD],
    input  wire bram_replicate_pkg::word_t  rd_data  [`BR_NUM_RD],
    input  wire logic                       exp_en,
    input  wire logic [7:0]                 exp_chan,
    input  wire bram_replicate_pkg::word_t  exp_data,
    input  wire logic [127:0]               test_name,
    output logic                            busy,
    output int                              check_count,
    output int                              error_count
);
    timeunit 1ns;
    timeprecision 1ps;

    bram_replicate_pkg::word_t model_mem [1 << `BR_ADDR_WIDTH];

    logic                      pend_we;   // Write seen last cycle, stored one edge later
    bram_replicate_pkg::addr_t pend_addr;
    bram_replicate_pkg::word_t pend_data;

    // Two-stage expectation pipeline per read channel
    logic                      p1_v [`BR_NUM_RD];
    logic                      p2_v [`BR_NUM_RD];
    bram_replicate_pkg::word_t p1_d [`BR_NUM_RD];
    bram_replicate_pkg::word_t p2_d [`BR_NUM_RD];
    logic                      p1_f [`BR_NUM_RD];
    logic                      p2_f [`BR_NUM_RD];
    bram_replicate_pkg::word_t p1_e [`BR_NUM_RD];
    bram_replicate_pkg::word_t p2_e [`BR_NUM_RD];
    logic [127:0]              p1_n [`BR_NUM_RD];
    logic [127:0]              p2_n [`BR_NUM_RD];

    initial begin
        check_count = 0;
        error_count = 0;
    end

    always_comb begin
        busy = 1'b0;
        for (int k = 0; k < `BR_NUM_RD; k++) begin
            busy = busy | p1_v[k] | p2_v[k];
        end
    end

    task automatic check_channel(input int k);
        if (p2_v[k]) begin
            check_count++;
            if (rd_valid[k] !== 1'b1) begin
                $display("FAILED %0s ch%0d rd_valid: expected 1, actual %b", p2_n[k], k,
                         rd_valid[k]);
                error_count++;
            end else begin
                if (rd_data[k] !== p2_d[k]) begin
                    $display("FAILED %0s ch%0d rd_data vs model: expected %h, actual %h",
                             p2_n[k], k, p2_d[k], rd_data[k]);
                    error_count++;
                end
                if (p2_f[k] && rd_data[k] !== p2_e[k]) begin
                    $display("FAILED %0s ch%0d rd_data vs file: expected %h, actual %h",
                             p2_n[k], k, p2_e[k], rd_data[k]);
                    error_count++;
                end
            end
        end else if (rd_valid[k] !== 1'b0) begin
            $display("FAILED %0s ch%0d rd_valid: expected 0, actual %b", p2_n[k], k,
                     rd_valid[k]);
            error_count++;
        end
    endtask

    // ####################
    // Compare at negedge
    // ####################

    always @(negedge clk) begin
        if (!arst_n) begin
            for (int k = 0; k < `BR_NUM_RD; k++) begin
                if (rd_valid[k] !== 1'b0) begin
                    $display("FAILED %0s ch%0d rd_valid in reset: expected 0, actual %b",
                             test_name, k, rd_valid[k]);
                    error_count++;
                end
                p1_v[k] = 1'b0;
                p2_v[k] = 1'b0;
                p1_n[k] = test_name;
                p2_n[k] = test_name;
            end
            pend_we = 1'b0;
        end else begin
            for (int k = 0; k < `BR_NUM_RD; k++) begin
                check_channel(k);
                p2_v[k] = p1_v[k];
                p2_d[k] = p1_d[k];
                p2_f[k] = p1_f[k];
                p2_e[k] = p1_e[k];
                p2_n[k] = p1_n[k];
                // Read sees the table before the pending write lands
                p1_v[k] = rd_en[k] && rd_bram[k];
                p1_d[k] = model_mem[rd_addr[k]];
                p1_f[k] = exp_en && exp_chan == k;
                p1_e[k] = exp_data;
                p1_n[k] = test_name;
            end
            if (pend_we) begin
                model_mem[pend_addr] = pend_data;
            end
            pend_we = 1'b0;
            if (wr_en[0] && wr_bram[0]) begin   // Channel 0 has priority
                pend_we   = 1'b1;
                pend_addr = wr_addr[0];
                pend_data = wr_data[0];
            end else if (wr_en[1] && wr_bram[1]) begin
                pend_we   = 1'b1;
                pend_addr = wr_addr[1];
                pend_data = wr_data[1];
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/replicate_input.txt
# kind test chan region addr data expected
# W write, R read, I idle; addr, data and expected in hex
W broadcast   0 1 03 a5a5 0000
I broadcast   0 0 00 0000 0000
R broadcast   0 1 03 0000 a5a5
R broadcast   1 1 03 0000 a5a5
R broadcast   2 1 03 0000 a5a5
W second_chan 1 1 07 1234 0000
I second_chan 0 0 00 0000 0000
R second_chan 1 1 07 0000 1234
W second_chan 0 1 08 beef 0000
W second_chan 1 1 09 cafe 0000
W second_chan 0 1 0a 0f0f 0000
I second_chan 0 0 00 0000 0000
R second_chan 0 1 08 0000 beef
R second_chan 1 1 09 0000 cafe
R second_chan 2 1 0a 0000 0f0f
R second_chan 2 1 07 0000 1234
W region_wr   0 0 03 dead 0000
W region_wr   1 0 07 dead 0000
I region_wr   0 0 00 0000 0000
R region_wr   0 1 03 0000 a5a5
R region_wr   2 1 07 0000 1234
R region_rd   0 0 03 0000 0000
R region_rd   1 0 08 0000 0000
R region_rd   1 1 08 0000 beef
R region_rd   2 0 09 0000 0000
I region_rd   0 0 00 0000 0000
W wr_timing   0 1 03 5555 0000
R wr_timing   1 1 03 0000 a5a5
R wr_timing   1 1 03 0000 5555
W pipeline    0 1 10 0001 0000
W pipeline    0 1 11 0002 0000
W pipeline    1 1 12 0003 0000
W pipeline    1 1 13 0004 0000
I pipeline    0 0 00 0000 0000
R pipeline    0 1 10 0000 0001
R pipeline    0 1 11 0000 0002
R pipeline    0 1 12 0000 0003
R pipeline    0 1 13 0000 0004
R pipeline    1 1 12 0000 0003
R pipeline    2 1 10 0000 0001

// File: verif/tb_bram_replicate.sv
`default_nettype none

`include "bram_replicate_config.svh"

module tb_bram_replicate;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LINE_LIMIT    = 500;
    localparam int DRAIN_TIMEOUT = 20;   // Cycles allowed for the last reads to return

    logic                      clk = 1'b0;
    logic                      arst_n = 1'b0;
    logic                      wr_en    [`BR_NUM_WR];
    logic                      wr_bram  [`BR_NUM_WR];
    bram_replicate_pkg::addr_t wr_addr  [`BR_NUM_WR];
    bram_replicate_pkg::word_t wr_data  [`BR_NUM_WR];
    logic                      rd_en    [`BR_NUM_RD];
    logic                      rd_bram  [`BR_NUM_RD];
    bram_replicate_pkg::addr_t rd_addr  [`BR_NUM_RD];
    logic                      rd_valid [`BR_NUM_RD];
    bram_replicate_pkg::word_t rd_data  [`BR_NUM_RD];

    logic                      exp_en;
    logic [7:0]                exp_chan;
    bram_replicate_pkg::word_t exp_data;
    logic [127:0]              test_name;
    logic                      busy;
    int                        check_count;
    int                        error_count;
    int                        tb_errors = 0;

    always #20 clk = ~clk;

    bram_replicate_top bram_replicate_top_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr_en    (wr_en),
        .wr_bram  (wr_bram),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_en    (rd_en),
        .rd_bram  (rd_bram),
        .rd_addr  (rd_addr),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

    bram_replicate_checker bram_replicate_checker_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .wr_en       (wr_en),
        .wr_bram     (wr_bram),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .rd_en       (rd_en),
        .rd_bram     (rd_bram),
        .rd_addr     (rd_addr),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .exp_en      (exp_en),
        .exp_chan    (exp_chan),
        .exp_data    (exp_data),
        .test_name   (test_name),
        .busy        (busy),
        .check_count (check_count),
        .error_count (error_count)
    );

    // ####################
    // Stimulus helpers
    // ####################

    task automatic drive_idle();
        for (int i = 0; i < `BR_NUM_WR; i++) begin
            wr_en[i]   <= 1'b0;
            wr_bram[i] <= 1'b0;
            wr_addr[i] <= '0;
            wr_data[i] <= '0;
        end
        for (int k = 0; k < `BR_NUM_RD; k++) begin
            rd_en[k]   <= 1'b0;
            rd_bram[k] <= 1'b0;
            rd_addr[k] <= '0;
        end
        exp_en   <= 1'b0;
        exp_chan <= '0;
        exp_data <= '0;
    endtask

    // One file line per rising edge
    task automatic apply_op(input logic [63:0] kind, input logic [127:0] name, input int chan,
                            input int region, input bram_replicate_pkg::addr_t addr,
                            input bram_replicate_pkg::word_t data,
                            input bram_replicate_pkg::word_t exp_word);
        @(posedge clk);
        drive_idle();
        test_name <= name;
        case (kind)
            "W": begin
                if (chan < 0 || chan >= `BR_NUM_WR) begin
                    $display("Write channel %0d in stimulus file is out of range", chan);
                    tb_errors++;
                end else begin
                    wr_en[chan]   <= 1'b1;
                    wr_bram[chan] <= region[0];
                    wr_addr[chan] <= addr;
                    wr_data[chan] <= data;
                end
            end
            "R": begin
                if (chan < 0 || chan >= `BR_NUM_RD) begin
                    $display("Read channel %0d in stimulus file is out of range", chan);
                    tb_errors++;
                end else begin
                    rd_en[chan]   <= 1'b1;
                    rd_bram[chan] <= region[0];
                    rd_addr[chan] <= addr;
                    exp_en        <= 1'b1;   // Expected word travels with the read
                    exp_chan      <= chan[7:0];
                    exp_data      <= exp_word;
                end
            end
            "I": ;
            default: begin
                $display("Unknown operation kind %0s in stimulus file", kind);
                tb_errors++;
            end
        endcase
    endtask

    initial begin
        int                        fd;
        int                        code;
        int                        lines;
        int                        chan;
        int                        region;
        int                        wait_cycles;
        logic                      done;
        logic [63:0]               kind;
        logic [127:0]              name;
        logic [8*120-1:0]          skip_line;
        bram_replicate_pkg::addr_t addr;
        bram_replicate_pkg::word_t data;
        bram_replicate_pkg::word_t exp_word;

        test_name = "reset";
        drive_idle();
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;

        fd = $fopen("verif/replicate_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open stimulus file verif/replicate_input.txt");
            tb_errors++;
        end else begin
            lines = 0;
            done  = 1'b0;
            while (!done && lines < LINE_LIMIT) begin
                code = $fscanf(fd, "%s", kind);
                if (code != 1) begin
                    done = 1'b1;
                end else if (kind == "#") begin
                    code = $fgets(skip_line, fd);   // Comment line
                end else begin
                    code = $fscanf(fd, "%s %d %d %h %h %h", name, chan, region, addr, data,
                                   exp_word);
                    if (code != 6) begin
                        $display("Stimulus line after operation %0d is malformed", lines);
                        tb_errors++;
                        done = 1'b1;
                    end else begin
                        apply_op(kind, name, chan, region, addr, data, exp_word);
                        lines++;
                    end
                end
            end
            if (!done) begin
                $display("Stimulus file holds more than %0d operations", LINE_LIMIT);
                tb_errors++;
            end
            $fclose(fd);
        end

        // Drain the read pipeline
        @(posedge clk);
        drive_idle();
        wait_cycles = 0;
        while (busy && wait_cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (busy) begin
            $display("Read results still pending after %0d cycles", DRAIN_TIMEOUT);
            tb_errors++;
        end

        $display("Checks: %0d, checker errors: %0d, testbench errors: %0d",
                 check_count, error_count, tb_errors);
        if (error_count == 0 && tb_errors == 0 && check_count > 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
